// ==== source/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// entries in each of the request and response queues
`define ACCESS_FIFO_DEPTH 4

// RAM size in 32-bit words, word address taken modulo this
`define WB_RAM_WORDS 256

// cycles from an accepted bus request to its ack
`define WB_RAM_LATENCY 1

// one stall cycle in every period of this many cycles
`define WB_RAM_REFRESH_PERIOD 16

`endif

// ==== source/cpu_access_pkg.sv ====
package cpu_access_pkg;

    // access width as seen by the CPU
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    typedef logic [31:0] cpu_word_t;

    // one queued request, 67 bits
    typedef struct packed {
        logic         write;
        access_size_t size;
        // byte address, any alignment
        logic [31:0]  addr;
        // write data in the low lanes
        cpu_word_t    data;
    } cpu_access_t;

endpackage

// ==== source/wb_bus_pkg.sv ====
package wb_bus_pkg;

    // word address, byte offset dropped
    typedef logic [29:0] wb_adr_t;

    // byte selects, bit 0 is the least significant lane
    typedef logic [3:0] wb_sel_t;

    typedef logic [31:0] wb_dat_t;

endpackage

// ==== source/access_fifo.sv ====
module access_fifo #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 4
) (
    input  logic I_clk,
    input  logic I_reset,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     front,
    output logic full,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    // front entry is visible without a clock
    assign front = mem[rd_ptr];

    assign do_pop  = pop && !empty;
    // a full queue still takes a push when a pop frees the slot
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge I_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/access_issuer.sv ====
module access_issuer (
    input  logic                       I_clk,
    input  logic                       I_reset,
    input  logic                       req_empty,
    input  cpu_access_pkg::cpu_access_t req_front,
    output logic                       req_pop,
    input  logic                       rsp_full,
    output logic                       rsp_push,
    output cpu_access_pkg::cpu_word_t  rsp_word,
    output logic                       bus_strobe,
    output logic                       bus_write,
    output logic                       bus_halfword,
    output logic                       bus_fullword,
    output cpu_access_pkg::cpu_word_t  bus_addr,
    output cpu_access_pkg::cpu_word_t  bus_wdata,
    input  logic                       bus_wait,
    input  cpu_access_pkg::cpu_word_t  bus_rdata
);

    import cpu_access_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STARTED,
        ST_ACTIVE
    } state_t;

    state_t      state;
    cpu_access_t req_q;
    cpu_word_t   size_mask;
    logic        done;

    // wait has fallen again, and a read needs room for its response
    assign done = (state == ST_ACTIVE) && !bus_wait && (req_q.write || !rsp_full);

    // strobe drops with wait so the bridge does not start over
    assign bus_strobe   = (state == ST_STARTED) || ((state == ST_ACTIVE) && bus_wait);
    assign bus_write    = req_q.write;
    assign bus_halfword = (req_q.size == SIZE_HALF);
    assign bus_fullword = (req_q.size == SIZE_WORD);
    assign bus_addr     = req_q.addr;
    assign bus_wdata    = req_q.data;

    // bridge keeps stale bytes above the access width
    always_comb begin
        case (req_q.size)
            SIZE_BYTE: size_mask = 32'h0000_00ff;
            SIZE_HALF: size_mask = 32'h0000_ffff;
            default:   size_mask = 32'hffff_ffff;
        endcase
    end

    assign rsp_word = bus_rdata & size_mask;
    assign req_pop  = done;
    assign rsp_push = done && !req_q.write;

    always_ff @(posedge I_clk) begin
        if ((state == ST_IDLE) && !req_empty) begin
            req_q <= req_front;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (!req_empty) state <= ST_STARTED;
                // bridge raises wait one cycle after strobe
                ST_STARTED: state <= ST_ACTIVE;
                ST_ACTIVE:  if (done) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/wb_bridge.sv ====
module wb_bridge (
    input  logic                      I_clk,
    input  logic                      I_reset,
    // CPU side
    input  logic                      strobe,
    input  logic                      write,
    input  logic                      halfword,
    input  logic                      fullword,
    input  cpu_access_pkg::cpu_word_t addr,
    input  cpu_access_pkg::cpu_word_t wdata,
    output cpu_access_pkg::cpu_word_t rdata,
    output logic                      bus_wait,
    // Wishbone pipelined master
    input  logic                      wb_ack,
    input  logic                      wb_stall,
    input  wb_bus_pkg::wb_dat_t       wb_dat_in,
    output wb_bus_pkg::wb_adr_t       wb_adr,
    output wb_bus_pkg::wb_dat_t       wb_dat_out,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output wb_bus_pkg::wb_sel_t       wb_sel
);

    import cpu_access_pkg::*;
    import wb_bus_pkg::*;

    logic        busy;
    cpu_word_t   buffer;
    logic [1:0]  offset;
    wb_sel_t     size_lanes;
    logic [7:0]  sel_pair;
    logic [1:0]  word_target;
    logic [1:0]  addr_count;
    logic [1:0]  ack_count;
    logic [1:0]  ack_count_next;
    wb_adr_t     base_adr;
    logic [63:0] wr_wide;
    logic [63:0] rd_dup;
    wb_sel_t     first_lanes;
    wb_sel_t     ack_lanes;
    logic        issue;
    logic        last_ack;

    assign bus_wait = busy;
    assign rdata    = buffer;

    assign offset   = addr[1:0];
    assign base_adr = addr[31:2];

    assign size_lanes = fullword ? 4'b1111 : (halfword ? 4'b0011 : 4'b0001);

    // low nibble selects the base word, high nibble the word after it
    assign sel_pair    = {4'b0000, size_lanes} << offset;
    assign word_target = (sel_pair[7:4] != 4'b0000) ? 2'd2 : 2'd1;

    // write bytes moved up onto their lanes across both words
    assign wr_wide = {32'h0000_0000, wdata} << {offset, 3'b000};

    // read lanes rotated down so lane offset lands in byte 0
    assign rd_dup      = {wb_dat_in, wb_dat_in} >> {offset, 3'b000};
    assign first_lanes = 4'b1111 >> offset;
    assign ack_lanes   = ack_count[0] ? ~first_lanes : first_lanes;

    // next request goes out when the bus slot is free or being taken now
    assign issue = strobe && (addr_count != word_target) && (!wb_stb || !wb_stall);

    assign ack_count_next = ack_count + 2'd1;
    assign last_ack       = strobe && wb_ack && (ack_count_next == word_target);

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy       <= 1'b0;
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            wb_we      <= 1'b0;
            addr_count <= 2'd0;
            ack_count  <= 2'd0;
        end else begin
            busy   <= strobe;
            wb_cyc <= strobe;
            wb_we  <= strobe && write;

            if (issue) begin
                wb_stb     <= 1'b1;
                addr_count <= addr_count + 2'd1;
            end else if (!strobe || !wb_stall) begin
                // stalled request stays on the bus
                wb_stb <= 1'b0;
            end

            if (strobe && wb_ack) begin
                ack_count <= ack_count_next;
            end

            // all words answered, ready for the next access
            if (last_ack) begin
                busy       <= 1'b0;
                addr_count <= 2'd0;
                ack_count  <= 2'd0;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (issue) begin
            wb_adr     <= base_adr + {28'd0, addr_count};
            wb_sel     <= addr_count[0] ? sel_pair[7:4] : sel_pair[3:0];
            wb_dat_out <= addr_count[0] ? wr_wide[63:32] : wr_wide[31:0];
        end
    end

    // merge acked bytes, upper bytes left as they were
    always_ff @(posedge I_clk) begin
        if (strobe && wb_ack && !write) begin
            for (int i = 0; i < 4; i++) begin
                if (ack_lanes[i]) begin
                    buffer[8*i +: 8] <= rd_dup[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== source/wb_ram.sv ====
`include "mem_macros.svh"

module wb_ram (
    input  logic                I_clk,
    input  logic                I_reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  wb_bus_pkg::wb_adr_t wb_adr,
    input  wb_bus_pkg::wb_dat_t wb_dat_in,
    input  wb_bus_pkg::wb_sel_t wb_sel,
    output logic                wb_ack,
    output logic                wb_stall,
    output wb_bus_pkg::wb_dat_t wb_dat_out
);

    import wb_bus_pkg::*;

    localparam int IDX_W = $clog2(`WB_RAM_WORDS);
    localparam int LAT   = `WB_RAM_LATENCY;
    localparam int REF_W = $clog2(`WB_RAM_REFRESH_PERIOD);

    wb_dat_t          mem [`WB_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             ack_pipe [LAT];
    wb_dat_t          dat_pipe [LAT];
    logic [REF_W-1:0] refresh_count;

    // word address wraps at the RAM size
    assign idx    = wb_adr[IDX_W-1:0];
    assign accept = wb_cyc && wb_stb && !wb_stall;

    // refresh takes the last cycle of each period
    assign wb_stall = (refresh_count == REF_W'(`WB_RAM_REFRESH_PERIOD - 1));

    assign wb_ack     = ack_pipe[LAT-1];
    assign wb_dat_out = dat_pipe[LAT-1];

    always_ff @(posedge I_clk) begin
        if (accept && wb_we) begin
            for (int i = 0; i < 4; i++) begin
                if (wb_sel[i]) begin
                    mem[idx][8*i +: 8] <= wb_dat_in[8*i +: 8];
                end
            end
        end
    end

    // read data travels alongside its ack
    always_ff @(posedge I_clk) begin
        dat_pipe[0] <= mem[idx];
        for (int i = 1; i < LAT; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            refresh_count <= '0;
            for (int i = 0; i < LAT; i++) begin
                ack_pipe[i] <= 1'b0;
            end
        end else begin
            if (wb_stall) begin
                refresh_count <= '0;
            end else begin
                refresh_count <= refresh_count + 1'b1;
            end
            ack_pipe[0] <= accept;
            for (int i = 1; i < LAT; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

endmodule

// ==== source/mem_subsystem.sv ====
`include "mem_macros.svh"

module mem_subsystem (
    input  logic                        I_clk,
    input  logic                        I_reset,
    input  logic                        req_push,
    input  cpu_access_pkg::cpu_access_t req_data,
    output logic                        req_full,
    input  logic                        rsp_pop,
    output cpu_access_pkg::cpu_word_t   rsp_data,
    output logic                        rsp_empty
);

    import cpu_access_pkg::*;
    import wb_bus_pkg::*;

    // request queue to issuer
    logic        req_empty;
    cpu_access_t req_front;
    logic        req_pop;

    // issuer to response queue
    logic      rsp_push;
    cpu_word_t rsp_word;
    logic      rsp_full;

    // CPU-side bus between issuer and bridge
    logic      bus_strobe;
    logic      bus_write;
    logic      bus_halfword;
    logic      bus_fullword;
    cpu_word_t bus_addr;
    cpu_word_t bus_wdata;
    cpu_word_t bus_rdata;
    logic      bus_wait;

    // Wishbone
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    logic    wb_ack;
    logic    wb_stall;
    wb_adr_t wb_adr;
    wb_sel_t wb_sel;
    wb_dat_t wb_wdat;
    wb_dat_t wb_rdat;

    access_fifo #(
        .T     (cpu_access_t),
        .DEPTH (`ACCESS_FIFO_DEPTH)
    ) req_fifo_i (
        .I_clk     (I_clk),
        .I_reset   (I_reset),
        .push      (req_push),
        .push_data (req_data),
        .pop       (req_pop),
        .front     (req_front),
        .full      (req_full),
        .empty     (req_empty)
    );

    access_issuer issuer_i (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .req_empty    (req_empty),
        .req_front    (req_front),
        .req_pop      (req_pop),
        .rsp_full     (rsp_full),
        .rsp_push     (rsp_push),
        .rsp_word     (rsp_word),
        .bus_strobe   (bus_strobe),
        .bus_write    (bus_write),
        .bus_halfword (bus_halfword),
        .bus_fullword (bus_fullword),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wait     (bus_wait),
        .bus_rdata    (bus_rdata)
    );

    wb_bridge bridge_i (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .strobe     (bus_strobe),
        .write      (bus_write),
        .halfword   (bus_halfword),
        .fullword   (bus_fullword),
        .addr       (bus_addr),
        .wdata      (bus_wdata),
        .rdata      (bus_rdata),
        .bus_wait   (bus_wait),
        .wb_ack     (wb_ack),
        .wb_stall   (wb_stall),
        .wb_dat_in  (wb_rdat),
        .wb_adr     (wb_adr),
        .wb_dat_out (wb_wdat),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_sel     (wb_sel)
    );

    wb_ram ram_i (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_in  (wb_wdat),
        .wb_sel     (wb_sel),
        .wb_ack     (wb_ack),
        .wb_stall   (wb_stall),
        .wb_dat_out (wb_rdat)
    );

    access_fifo #(
        .T     (cpu_word_t),
        .DEPTH (`ACCESS_FIFO_DEPTH)
    ) rsp_fifo_i (
        .I_clk     (I_clk),
        .I_reset   (I_reset),
        .push      (rsp_push),
        .push_data (rsp_word),
        .pop       (rsp_pop),
        .front     (rsp_data),
        .full      (rsp_full),
        .empty     (rsp_empty)
    );

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== sim/tb_mem_subsystem.sv ====
module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_access_pkg::*;

    localparam int TIMEOUT      = 200;
    localparam int RANDOM_PAIRS = 24;
    localparam int POP_GAP      = 6;

    logic        I_clk;
    logic        I_reset;
    logic        req_push;
    cpu_access_t req_data;
    logic        req_full;
    logic        rsp_pop;
    cpu_word_t   rsp_data;
    logic        rsp_empty;

    // byte image of the RAM, 256 words
    logic [7:0]  model [1024];
    cpu_word_t   exp_q [$];
    int          value_errors;
    int          count_errors;
    int          other_errors;
    int          reads_sent;
    int          rsp_seen;
    logic        sending_done;
    logic        timed_out;
    logic        full_seen;
    integer      seed;

    tb_clock clock_i (
        .clk   (I_clk),
        .reset (I_reset)
    );

    mem_subsystem dut_i (
        .I_clk     (I_clk),
        .I_reset   (I_reset),
        .req_push  (req_push),
        .req_data  (req_data),
        .req_full  (req_full),
        .rsp_pop   (rsp_pop),
        .rsp_data  (rsp_data),
        .rsp_empty (rsp_empty)
    );

    function automatic int byte_count(input access_size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian, lowest address in the lowest byte
    function automatic void model_write(input cpu_access_t r);
        for (int i = 0; i < byte_count(r.size); i++) begin
            model[10'(r.addr + 32'(i))] = r.data[8*i +: 8];
        end
    endfunction

    // bytes above the access width read as zero
    function automatic cpu_word_t model_read(input logic [31:0] addr, input access_size_t size);
        cpu_word_t w;
        w = '0;
        for (int i = 0; i < byte_count(size); i++) begin
            w[8*i +: 8] = model[10'(addr + 32'(i))];
        end
        return w;
    endfunction

    task automatic check_word(input string name, input cpu_word_t got, input cpu_word_t expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
            count_errors++;
        end
    endtask

    task automatic send_request(input cpu_access_t r, input cpu_word_t expected);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        @(negedge I_clk);
        if (req_full) begin
            full_seen = 1'b1;
        end
        while (req_full && waited < TIMEOUT) begin
            @(negedge I_clk);
            waited++;
        end
        if (req_full) begin
            $display("Timeout: request queue stayed full for %0d cycles", TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
            return;
        end
        if (r.write) begin
            model_write(r);
        end else begin
            exp_q.push_back(expected);
            reads_sent++;
        end
        @(posedge I_clk);
        req_push <= 1'b1;
        req_data <= r;
        // push takes effect on this edge
        @(posedge I_clk);
        req_push <= 1'b0;
    endtask

    task automatic run_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] op;
        logic [31:0] size;
        logic [31:0] addr;
        logic [31:0] data;
        cpu_access_t r;
        fd = $fopen("sim/access_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/access_vectors.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd) && !timed_out) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%h %h %h %h", op, size, addr, data);
                if (code == 4) begin
                    r.write = op[0];
                    r.size  = access_size_t'(size[1:0]);
                    r.addr  = addr;
                    r.data  = op[0] ? data : '0;
                    send_request(r, data);
                end
            end
        end
        $fclose(fd);
    endtask

    // word writes at any alignment in the upper quarter, then readback
    task automatic run_random();
        logic [31:0] addrs [RANDOM_PAIRS];
        cpu_access_t r;
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            addrs[i] = 32'h300 + ($unsigned($random(seed)) % 252);
            r.write  = 1'b1;
            r.size   = SIZE_WORD;
            r.addr   = addrs[i];
            r.data   = $random(seed);
            send_request(r, '0);
        end
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            r.write = 1'b0;
            r.size  = SIZE_WORD;
            r.addr  = addrs[i];
            r.data  = '0;
            send_request(r, model_read(addrs[i], SIZE_WORD));
        end
    endtask

    task automatic accept_response(input cpu_word_t got);
        rsp_seen++;
        if (exp_q.size() == 0) begin
            $display("Response %h arrived with no read outstanding", got);
            count_errors++;
        end else begin
            check_word("rsp_data", got, exp_q.pop_front());
        end
    endtask

    // pops spaced out so the response queue fills and holds the issuer
    task automatic collect_responses();
        int        idle;
        logic      take;
        cpu_word_t got;
        idle = 0;
        while (!timed_out && !(sending_done && rsp_seen >= reads_sent)) begin
            @(negedge I_clk);
            take = !rsp_empty;
            got  = rsp_data;
            @(posedge I_clk);
            rsp_pop <= take;
            if (take) begin
                accept_response(got);
                idle = 0;
                @(posedge I_clk);
                rsp_pop <= 1'b0;
                repeat (POP_GAP) @(posedge I_clk);
            end else if (rsp_seen < reads_sent) begin
                idle++;
                if (idle >= TIMEOUT) begin
                    $display("Timeout: no read response for %0d cycles", TIMEOUT);
                    other_errors++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    initial begin
        int waited;
        req_push     = 1'b0;
        req_data     = '0;
        rsp_pop      = 1'b0;
        value_errors = 0;
        count_errors = 0;
        other_errors = 0;
        reads_sent   = 0;
        rsp_seen     = 0;
        sending_done = 1'b0;
        timed_out    = 1'b0;
        full_seen    = 1'b0;
        seed         = 32'ha239;
        waited       = 0;
        while (I_reset !== 1'b0 && waited < TIMEOUT) begin
            @(negedge I_clk);
            waited++;
        end
        if (I_reset !== 1'b0) begin
            $display("Timeout: reset never released");
            other_errors++;
            timed_out = 1'b1;
        end
        fork
            begin
                run_vectors();
                run_random();
                sending_done = 1'b1;
            end
            collect_responses();
        join
        // quiet window, any response left now is an extra one
        repeat (20) @(negedge I_clk);
        check_count("read responses", rsp_seen + (rsp_empty ? 0 : 1), reads_sent);
        if (!full_seen) begin
            $display("The request queue never became full during the burst");
            other_errors++;
        end
        $display("Errors: %0d value, %0d count, %0d other", value_errors, count_errors,
                 other_errors);
        if (value_errors + count_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/access_vectors.txt ====
# op (1 write, 0 read)  size (0 byte, 1 half, 2 word)  byte address  data
# data is write data for a write, expected zero-extended result for a read
1 2 00000000 03020100
1 2 00000004 07060504
1 2 00000008 0b0a0908
1 2 0000000c 0f0e0d0c
0 2 00000000 03020100
0 2 00000004 07060504
0 2 0000000c 0f0e0d0c
0 0 00000004 00000004
0 0 00000005 00000005
0 0 00000006 00000006
0 0 00000007 00000007
0 1 00000008 00000908
0 1 00000009 00000a09
0 1 0000000a 00000b0a
0 1 0000000b 00000c0b
1 2 00000010 13121110
1 2 00000014 17161514
1 2 00000018 1b1a1918
1 1 00000013 5555bbaa
0 2 00000010 aa121110
0 2 00000014 171615bb
1 2 00000016 44332211
0 2 00000014 221115bb
0 2 00000018 1b1a4433
0 2 00000001 04030201
0 2 00000002 05040302
0 2 00000003 06050403
0 1 00000007 00000807
0 2 00000015 33221115
1 0 00000020 000000e0
1 0 00000021 000000e1
1 1 00000022 0000e3e2
0 2 00000020 e3e2e1e0
0 0 00000022 000000e2
0 1 00000001 00000201
0 2 00000008 0b0a0908
0 2 00001004 07060504

// ==== sim.f ====
+incdir+source
source/cpu_access_pkg.sv
source/wb_bus_pkg.sv
source/access_fifo.sv
source/access_issuer.sv
source/wb_bridge.sv
source/wb_ram.sv
source/mem_subsystem.sv
sim/tb_clock.sv
sim/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile and run the testbench with Verilator, fail on a reported failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_subsystem \
    -f sim.f \
    -Mdir obj_dir

./obj_dir/Vtb_mem_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0
